// ==== Makefile ====
# Verilator simulation of the keypad text unit

VERILATOR ?= verilator
TOP       ?= keypad_text_tb
FILELIST  ?= keypad_text.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== keypad_text.f ====
source/keypad_pkg.sv
source/key_decoder.sv
source/controls.sv
source/char_encoder.sv
source/msg_buffer.sv
source/keypad_text_top.sv
verification/keypad_text_chk.sv
verification/keypad_text_tb.sv

// ==== source/char_encoder.sv ====
`timescale 1ns/1ps

module char_encoder
  import keypad_pkg::*;
(
  input  enc_sel_t   sel,
  output logic [7:0] char
);

  logic [7:0] digit;  // number mode character
  logic [7:0] base;   // first letter of the key, 0 if none
  logic [7:0] sym;    // letter mode character of a non-letter key
  logic       four;   // key carries four letters
  logic [1:0] pos;    // letter position on the key
  logic [7:0] letter;

  // number mode table
  always_comb begin
    case (sel.idx)
      4'd0:      digit = "1";
      4'd1:      digit = "2";
      4'd2:      digit = "3";
      4'd4:      digit = "4";
      4'd5:      digit = "5";
      4'd6:      digit = "6";
      4'd8:      digit = "7";
      4'd9:      digit = "8";
      4'd10:     digit = "9";
      4'd13:     digit = "0";
      IDX_STAR:  digit = "*";
      IDX_SPACE: digit = " ";
      default:   digit = 8'h00; // function keys are not characters
    endcase
  end

  // letter mode table
  always_comb begin
    base = 8'h00;
    sym  = 8'h00;
    four = 1'b0;
    case (sel.idx)
      4'd0:      sym = ".";
      4'd1:      base = "a";
      4'd2:      base = "d";
      4'd4:      base = "g";
      4'd5:      base = "j";
      4'd6:      base = "m";
      4'd8: begin
        base = "p"; // pqrs
        four = 1'b1;
      end
      4'd9:      base = "t";
      4'd10: begin
        base = "w"; // wxyz
        four = 1'b1;
      end
      4'd13:     sym = " ";
      IDX_STAR:  sym = "*";
      IDX_SPACE: sym = " ";
      default:   sym = 8'h00;
    endcase
  end

  // count modulo letters on key, count only reaches 3
  assign pos    = (four || sel.count != 2'd3) ? sel.count : 2'd0;
  assign letter = base + 8'(pos);

  always_comb begin
    if (!sel.mode) begin
      char = digit;
    end else if (base != 8'h00) begin
      char = sel.upper ? letter - CASE_OFFSET : letter; // capitals sit 0x20 lower
    end else begin
      char = sym;
    end
  end

endmodule

// ==== source/controls.sv ====
`timescale 1ns/1ps

module controls
  import keypad_pkg::*;
(
  input  logic     clk,
  input  logic     nrst,
  input  key_t     key,
  input  keycode_u keycode, // registered together with key
  input  logic     busy,
  output enc_sel_t sel,
  output buf_cmd_t cmd,
  output logic     mode,
  output logic     upper
);

  logic [7:0] prev_code;  // last accepted press
  logic [1:0] count;      // repeat count of last press
  logic       accept;
  logic       same_key;
  logic [1:0] next_count;
  logic       next_mode;
  logic       next_upper;
  buf_cmd_t   next_cmd;

  // a send still sitting in cmd counts as busy, the buffer sees it next edge
  assign accept   = key.valid & ~busy & ~cmd.send;
  assign same_key = (keycode.raw == prev_code);

  // repeat count, 0 on a new key, then 1 2 3 1 2 3 ...
  always_comb begin
    if (!same_key) begin
      next_count = 2'd0;
    end else if (count == 2'd3) begin
      next_count = 2'd1;
    end else begin
      next_count = count + 2'd1;
    end
  end

  // key function decode
  always_comb begin
    next_mode  = mode;
    next_upper = upper;
    next_cmd   = '0;
    case (keycode.raw)
      KEY_MODE: begin
        next_mode = ~mode;   // no buffer command
      end
      KEY_SHIFT: begin
        next_upper = ~upper; // no buffer command
      end
      KEY_CLEAR: begin
        next_upper     = 1'b0;
        next_cmd.clear = 1'b1;
      end
      KEY_SEND: begin
        next_cmd.send = 1'b1;
      end
      default: begin
        // repeated letter tap overwrites the pending character
        if (mode && next_count != 2'd0) begin
          next_cmd.replace = 1'b1;
        end else begin
          next_cmd.write = 1'b1;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      prev_code <= '0; // never a valid code, first press counts 0
      count     <= '0;
      mode      <= 1'b0; // number mode
      upper     <= 1'b0;
      cmd       <= '0;
    end else begin
      cmd <= accept ? next_cmd : '0;
      if (accept) begin
        prev_code <= keycode.raw;
        mode      <= next_mode;
        upper     <= next_upper;
        if (keycode.raw == KEY_CLEAR) begin
          count <= 2'd0;
        end else begin
          count <= next_count;
        end
      end
    end
  end

  // encoder select travels with cmd, mode and case as they were before the press
  always_ff @(posedge clk) begin
    if (accept) begin
      sel.idx   <= key.idx;
      sel.mode  <= mode;
      sel.upper <= upper;
      sel.count <= next_count;
    end
  end

endmodule

// ==== source/key_decoder.sv ====
`timescale 1ns/1ps

module key_decoder
  import keypad_pkg::*;
(
  input  logic     clk,
  input  logic     nrst,
  input  logic     key_strobe,
  input  keycode_u keycode,
  output key_t     key
);

  logic       row_ok;  // exactly one row bit
  logic       col_ok;  // exactly one column bit
  logic [1:0] row_idx;
  logic [1:0] col_idx;

  // position of the set bit, only meaningful for one-hot input
  function automatic logic [1:0] onehot_to_bin(input logic [3:0] oh);
    logic [1:0] bin;
    bin = 2'd0;
    for (int i = 0; i < 4; i++) begin
      if (oh[i]) begin
        bin = 2'(i);
      end
    end
    return bin;
  endfunction

  assign row_ok  = $onehot(keycode.rc.row);
  assign col_ok  = $onehot(keycode.rc.col);
  assign row_idx = onehot_to_bin(keycode.rc.row);
  assign col_idx = onehot_to_bin(keycode.rc.col);

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      key <= '0;
    end else begin
      // malformed codes are dropped here and never reach the controls
      key.valid <= key_strobe & row_ok & col_ok;
      key.idx   <= {row_idx, col_idx}; // row * 4 + col
    end
  end

endmodule

// ==== source/keypad_pkg.sv ====
package keypad_pkg;

  // raw scanner codes of the function keys, upper nibble row, lower nibble column
  localparam logic [7:0] KEY_MODE  = 8'h28; // B, row 1 col 3
  localparam logic [7:0] KEY_SHIFT = 8'h84; // #, row 3 col 2
  localparam logic [7:0] KEY_CLEAR = 8'h48; // C, row 2 col 3
  localparam logic [7:0] KEY_SEND  = 8'h88; // D, row 3 col 3

  // key index is row * 4 + col
  localparam logic [3:0] IDX_SPACE = 4'd3;  // A
  localparam logic [3:0] IDX_MODE  = 4'd7;  // B
  localparam logic [3:0] IDX_CLEAR = 4'd11; // C
  localparam logic [3:0] IDX_STAR  = 4'd12; // *
  localparam logic [3:0] IDX_SHIFT = 4'd14; // #
  localparam logic [3:0] IDX_SEND  = 4'd15; // D

  // message storage
  localparam int MSG_DEPTH = 16; // characters held
  localparam int MSG_AW    = 4;  // address width
  localparam int MSG_LW    = 5;  // length width, counts 0..MSG_DEPTH

  // lower to upper case distance in ascii
  localparam logic [7:0] CASE_OFFSET = 8'h20;

  // one-hot row and column halves of a keycode
  typedef struct packed {
    logic [3:0] row;
    logic [3:0] col;
  } rowcol_t;

  // scanner word, compared as a byte or split into row/col
  typedef union packed {
    logic [7:0] raw;
    rowcol_t    rc;
  } keycode_u;

  // decoded press, decoder to controls
  typedef struct packed {
    logic       valid;
    logic [3:0] idx;
  } key_t;

  // character select, controls to encoder
  typedef struct packed {
    logic [3:0] idx;
    logic       mode;  // 1 = letter mode
    logic       upper;
    logic [1:0] count; // repeat count of this press
  } enc_sel_t;

  // buffer command, at most one bit set
  typedef struct packed {
    logic write;
    logic replace;
    logic send;
    logic clear;
  } buf_cmd_t;

endpackage

// ==== source/keypad_text_top.sv ====
`timescale 1ns/1ps

module keypad_text_top
  import keypad_pkg::*;
(
  input  logic              clk,
  input  logic              nrst,
  input  logic              key_strobe,
  input  keycode_u          keycode,
  output logic              tx_valid,
  output logic [7:0]        tx_data,
  output logic              tx_last,
  output logic              mode,
  output logic              upper,
  output logic [MSG_LW-1:0] msg_len
);

  key_t       key;
  keycode_u   key_code; // registered raw code, aligned with key
  enc_sel_t   sel;
  buf_cmd_t   cmd;
  logic [7:0] char;
  logic       busy;

  // valid presses are one-hot, so the raw byte follows from the index
  assign key_code.rc.row = 4'b0001 << key.idx[3:2];
  assign key_code.rc.col = 4'b0001 << key.idx[1:0];

  key_decoder u_dec (.clk, .nrst, .key_strobe, .keycode, .key);

  controls u_ctrl (.clk, .nrst, .key, .keycode(key_code), .busy, .sel, .cmd, .mode, .upper);

  char_encoder u_enc (.sel, .char);

  msg_buffer u_buf (
    .clk, .nrst, .cmd, .char, .busy, .msg_len, .tx_valid, .tx_data, .tx_last
  );

endmodule

// ==== source/msg_buffer.sv ====
`timescale 1ns/1ps

module msg_buffer
  import keypad_pkg::*;
(
  input  logic              clk,
  input  logic              nrst,
  input  buf_cmd_t          cmd,
  input  logic [7:0]        char,
  output logic              busy,     // stream in progress
  output logic [MSG_LW-1:0] msg_len,
  output logic              tx_valid,
  output logic [7:0]        tx_data,
  output logic              tx_last
);

  logic [7:0]        mem [MSG_DEPTH];
  logic [MSG_AW-1:0] rd_ptr;     // next address to stream
  logic [MSG_AW-1:0] last_addr;  // address of newest character
  logic [MSG_AW-1:0] wr_addr;
  logic [MSG_AW-1:0] tx_addr;
  logic              empty;
  logic              full;
  logic              do_append;
  logic              do_replace;
  logic              wr_en;
  logic              tx_fire;    // a character leaves this cycle
  logic              tx_end;     // ... and it is the final one

  assign empty     = (msg_len == '0);
  assign full      = (msg_len == MSG_LW'(MSG_DEPTH));
  assign last_addr = msg_len[MSG_AW-1:0] - 1'b1; // wraps right at full length

  // replace on empty message falls back to append, appends drop when full
  assign do_append  = (cmd.write | (cmd.replace & empty)) & ~full;
  assign do_replace = cmd.replace & ~empty;
  assign wr_en      = do_append | do_replace;
  assign wr_addr    = do_replace ? last_addr : msg_len[MSG_AW-1:0];

  // first character goes out on the send edge itself
  assign tx_fire = busy | (cmd.send & ~empty);
  assign tx_addr = busy ? rd_ptr : '0;
  assign tx_end  = tx_fire & (tx_addr == last_addr);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= char;
    end
  end

  always_ff @(posedge clk) begin
    if (tx_fire) begin
      tx_data <= mem[tx_addr];
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      msg_len  <= '0;
      busy     <= 1'b0;
      rd_ptr   <= '0;
      tx_valid <= 1'b0;
      tx_last  <= 1'b0;
    end else begin
      tx_valid <= tx_fire;
      tx_last  <= tx_end;
      if (tx_fire) begin
        rd_ptr <= tx_addr + 1'b1;
      end
      if (tx_end) begin
        busy <= 1'b0; // single char message never raises busy
      end else if (tx_fire) begin
        busy <= 1'b1;
      end
      if (cmd.clear || tx_end) begin
        msg_len <= '0; // sent messages are dropped
      end else if (do_append) begin
        msg_len <= msg_len + 1'b1;
      end
    end
  end

endmodule

// ==== verification/keypad_text_chk.sv ====
`timescale 1ns/1ps

module keypad_text_chk
  import keypad_pkg::*;
(
  input logic              clk,
  input logic              nrst,
  input buf_cmd_t          cmd,
  input logic              busy,
  input logic              tx_valid,
  input logic              tx_last,
  input logic [MSG_LW-1:0] msg_len
);

  // last flag only ever rides on a valid character
  last_needs_valid: assert property (@(posedge clk) disable iff (!nrst)
    tx_last |-> tx_valid)
    else $error("tx_last high while tx_valid is low");

  // controls hold off while the buffer streams
  no_cmd_when_busy: assert property (@(posedge clk) disable iff (!nrst)
    busy |-> (cmd == '0))
    else $error("buffer command issued while busy");

  one_cmd_bit: assert property (@(posedge clk) disable iff (!nrst)
    $onehot0(cmd))
    else $error("more than one buffer command bit set");

  len_in_range: assert property (@(posedge clk) disable iff (!nrst)
    msg_len <= MSG_LW'(MSG_DEPTH))
    else $error("message length beyond buffer depth");

endmodule

bind msg_buffer keypad_text_chk u_buf_chk (
  .clk, .nrst, .cmd, .busy, .tx_valid, .tx_last, .msg_len
);

// ==== verification/keypad_text_tb.sv ====
`timescale 1ns/1ps

module keypad_text_tb
  import keypad_pkg::*;
();

  localparam int N_RAND    = 300;  // random presses
  localparam int PRESS_EST = 800;  // directed plus random presses
  localparam int SEND_EST  = 150;  // sends, each drained at most once
  localparam int LIMIT     = (PRESS_EST + SEND_EST * (MSG_DEPTH + 8)) * 4; // margin 4

  logic              clk;
  logic              nrst;
  logic              key_strobe;
  keycode_u          keycode;
  logic              tx_valid;
  logic [7:0]        tx_data;
  logic              tx_last;
  logic              mode;
  logic              upper;
  logic [MSG_LW-1:0] msg_len;

  int    cyc;
  int    errors;
  int    checks;
  string test_name;
  int    blk_lo;  // window of strobe edges lost to a send
  int    blk_hi;

  // reference state
  logic       m_mode;
  logic       m_upper;
  logic [7:0] m_prev;
  int         m_count;
  logic [7:0] m_msg[$];
  logic [7:0] exp_data[$]; // expected stream characters, in order
  logic       exp_last[$];
  logic [7:0] exp_char;
  logic       exp_flag;

  keypad_text_top uut (
    .clk, .nrst, .key_strobe, .keycode, .tx_valid, .tx_data, .tx_last, .mode, .upper, .msg_len
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > LIMIT) begin
      $display("timeout after %0d cycles in test %s", cyc, test_name);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic int bit_pos(input logic [3:0] oh);
    for (int i = 0; i < 4; i++) begin
      if (oh[i]) begin
        return i;
      end
    end
    return 0;
  endfunction

  function automatic logic [7:0] code_of(input int row, input int col);
    return {4'(1 << row), 4'(1 << col)};
  endfunction

  function automatic logic [7:0] char_code(input logic [7:0] ch);
    string layout;
    layout = "123A456B789C*0#D";
    for (int i = 0; i < 16; i++) begin
      if (layout[i] == ch) begin
        return code_of(i / 4, i % 4);
      end
    end
    return 8'h00;
  endfunction

  // character of a press, straight from the keypad legend
  function automatic logic [7:0] ref_char(input logic [7:0] code, input logic lmode,
                                          input logic lupper, input int count);
    string      layout;
    string      letters;
    logic [7:0] ch;
    logic [7:0] c;
    layout = "123A456B789C*0#D";
    ch = layout[bit_pos(code[7:4]) * 4 + bit_pos(code[3:0])];
    if (!lmode) begin
      return (ch == "A") ? 8'h20 : ch;
    end
    case (ch)
      "1": return ".";
      "0", "A": return 8'h20;
      "*": return "*";
      "2": letters = "abc";
      "3": letters = "def";
      "4": letters = "ghi";
      "5": letters = "jkl";
      "6": letters = "mno";
      "7": letters = "pqrs";
      "8": letters = "tuv";
      "9": letters = "wxyz";
      default: return 8'h00;
    endcase
    c = letters[count % letters.len()];
    return lupper ? c - 8'h20 : c;
  endfunction

  // reference model, one accepted press
  function automatic void apply_press(input logic [7:0] code);
    int         new_count;
    logic [7:0] ch;
    int         n;
    new_count = (code == m_prev) ? ((m_count == 3) ? 1 : m_count + 1) : 0;
    case (code)
      KEY_MODE:  m_mode = ~m_mode;
      KEY_SHIFT: m_upper = ~m_upper;
      KEY_CLEAR: begin
        m_msg.delete();
        m_upper = 1'b0;
      end
      KEY_SEND: begin
        n = m_msg.size();
        for (int i = 0; i < n; i++) begin
          exp_data.push_back(m_msg[i]);
          exp_last.push_back(i == n - 1);
        end
        m_msg.delete(); // message goes out and is dropped
      end
      default: begin
        ch = ref_char(code, m_mode, m_upper, new_count);
        if (m_mode && new_count != 0 && m_msg.size() != 0) begin
          m_msg[m_msg.size() - 1] = ch;
        end else if (m_msg.size() < MSG_DEPTH) begin
          m_msg.push_back(ch);
        end
      end
    endcase
    m_count = (code == KEY_CLEAR) ? 0 : new_count;
    m_prev  = code;
  endfunction

  // strobe stays up until the next press or idle
  task automatic press(input logic [7:0] code);
    int p;
    int n;
    @(negedge clk);
    key_strobe  = 1'b1;
    keycode.raw = code;
    p = cyc + 1; // edge that samples this strobe
    if ($onehot(code[7:4]) && $onehot(code[3:0]) && !(p >= blk_lo && p <= blk_hi)) begin
      if (code == KEY_SEND) begin
        n = m_msg.size();
        blk_lo = p + 1;
        blk_hi = p + ((n > 0) ? n : 1);
      end
      apply_press(code);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      key_strobe  = 1'b0;
      keycode.raw = 8'h00;
    end
  endtask

  task automatic press_str(input string s);
    for (int i = 0; i < s.len(); i++) begin
      press(char_code(s[i]));
    end
  endtask

  task automatic drain();
    idle(1);
    while (exp_data.size() != 0) begin
      idle(1);
    end
    idle(4);
  endtask

  // outputs against model once everything has settled
  task automatic check_state();
    drain();
    checks += 3;
    assert (mode == m_mode) else begin
      errors++;
      $display("Error: %s mode expected %0d got %0d", test_name, m_mode, mode);
    end
    assert (upper == m_upper) else begin
      errors++;
      $display("Error: %s upper expected %0d got %0d", test_name, m_upper, upper);
    end
    assert (msg_len == MSG_LW'(m_msg.size())) else begin
      errors++;
      $display("Error: %s msg_len expected %0d got %0d", test_name, m_msg.size(), msg_len);
    end
  endtask

  // compare every streamed character
  always @(negedge clk) begin
    if (nrst && tx_valid) begin
      assert (exp_data.size() != 0) else begin
        errors++;
        $display("character %h came out with no message pending in test %s",
                 tx_data, test_name);
      end
      if (exp_data.size() != 0) begin
        exp_char = exp_data.pop_front();
        exp_flag = exp_last.pop_front();
        checks += 2;
        assert (tx_data == exp_char) else begin
          errors++;
          $display("Error: %s tx_data expected %h got %h", test_name, exp_char, tx_data);
        end
        assert (tx_last == exp_flag) else begin
          errors++;
          $display("Error: %s tx_last expected %0d got %0d", test_name, exp_flag, tx_last);
        end
      end
    end
  end

  initial begin
    int r;
    int gap;
    logic [7:0] last_code;
    string letter_keys;
    clk         = 1'b0;
    nrst        = 1'b0;
    key_strobe  = 1'b0;
    keycode.raw = 8'h00;
    cyc         = 0;
    errors      = 0;
    checks      = 0;
    blk_lo      = -10;
    blk_hi      = -10;
    m_mode      = 1'b0;
    m_upper     = 1'b0;
    m_prev      = 8'h00;
    m_count     = 0;
    last_code   = 8'h11;
    letter_keys = "23456789";
    test_name   = "reset";
    void'($urandom(53036));
    repeat (10) @(posedge clk);
    @(negedge clk);
    nrst = 1'b1;
    check_state();

    test_name = "number_mode";
    press_str("1234567890*A");
    press(KEY_SEND);
    check_state();

    test_name = "multi_tap";
    press(KEY_MODE);
    check_state();
    for (int d = 0; d < 8; d++) begin
      for (int t = 1; t <= 8; t++) begin
        repeat (t) press(char_code(letter_keys[d]));
        press(KEY_SEND);
        drain();
      end
    end
    press_str("22333"); // new key starts a new character
    press(KEY_SEND);
    check_state();

    test_name = "case_mode";
    press(KEY_SHIFT);
    check_state();
    press_str("22");
    press(KEY_SHIFT);
    press_str("2");
    check_state();
    press(KEY_SHIFT);
    press_str("4");
    press(KEY_CLEAR);
    check_state();
    press(KEY_SEND); // empty, nothing may stream
    drain();
    press(KEY_MODE);
    check_state();
    press(KEY_MODE);
    check_state();

    test_name = "malformed";
    press(char_code("5"));
    press(8'h00);
    press(char_code("5"));
    press(8'h31);
    press(char_code("5"));
    press(8'h13);
    press(8'hF0);
    press(char_code("5"));
    press(KEY_SEND);
    check_state();
    press(KEY_MODE);
    press_str("12345678901234567890");
    check_state(); // only 16 kept
    press(KEY_SEND);
    check_state();

    test_name = "random";
    for (int n = 0; n < N_RAND; n++) begin
      r = $urandom % 20;
      if (r < 16) begin
        last_code = code_of(r / 4, r % 4);
      end else if (r < 18) begin
        last_code = KEY_SEND;
      end else if (r == 18) begin
        last_code = 8'($urandom);
      end
      press(last_code); // r == 19 repeats the previous code
      gap = $urandom % 4;
      if (gap != 0) begin
        idle(gap);
      end
    end
    idle(MSG_DEPTH + 4); // let a pending send finish before the final one
    press(KEY_SEND);
    check_state();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
